//--- hw/lsu_pkg.sv
package lsu_pkg;

  // bus and datapath widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // direct-mapped L1D, one word per line
  localparam int L1D_IDX_W = 4;
  localparam int L1D_LINES = 1 << L1D_IDX_W;
  localparam int L1D_TAG_W = ADDR_W - L1D_IDX_W - 2;

  // cacheable windows, lower bound inclusive, upper bound exclusive
  localparam logic [ADDR_W-1:0] CACHE_WIN0_LO = 32'h3000_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN0_HI = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN1_LO = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN1_HI = 32'h8040_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN2_LO = 32'hA000_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN2_HI = 32'hC000_0000;

  // operation codes from the execute stage
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LBU  = 4'd2,
    OP_LH   = 4'd3,
    OP_LHU  = 4'd4,
    OP_LW   = 4'd5,
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } lsu_op_e;

  // request from the execute stage
  typedef struct packed {
    lsu_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } lsu_req_t;

  // read request fields toward the bus
  typedef struct packed {
    logic [ADDR_W-1:0]   araddr;
    logic [STRB_W-1:0]   rstrb;
  } bus_rd_req_t;

  // write request fields toward the bus
  typedef struct packed {
    logic [ADDR_W-1:0]   awaddr;
    logic [DATA_W-1:0]   wdata;
    logic [STRB_W-1:0]   wstrb;
  } bus_wr_req_t;

  // memory word, seen whole or as bytes
  typedef union packed {
    logic [DATA_W-1:0]       word;
    logic [STRB_W-1:0][7:0]  bytes;
  } lsu_word_u;

endpackage

//--- hw/lsu_addr_ctrl.sv
module lsu_addr_ctrl (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        addr_strobe_i,
  input  logic                        req_valid_i,
  input  lsu_pkg::lsu_req_t           req_i,
  input  logic                        hit_i,
  input  logic                        bus_wready_i,
  output logic [lsu_pkg::ADDR_W-1:0]  eff_addr_o,
  output logic                        is_load_o,
  output logic                        is_store_o,
  output lsu_pkg::lsu_op_e            op_o,
  output lsu_pkg::bus_rd_req_t        bus_rd_o,
  output logic                        bus_arvalid_o,
  output lsu_pkg::bus_wr_req_t        bus_wr_o,
  output logic                        bus_wvalid_o,
  output logic                        wready_o
);

  import lsu_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [STRB_W-1:0] rstrb;
  logic [STRB_W-1:0] wstrb;
  logic              is_load;
  logic              is_store;

  // address is only valid with the strobe, so keep a copy
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      addr_q <= '0;
    end
    else if (addr_strobe_i)
    begin
      addr_q <= req_i.addr;
    end
  end

  // new address passes straight through in the strobe cycle
  assign eff_addr_o = addr_strobe_i ? req_i.addr : addr_q;

  // op decode into direction and byte strobes
  always_comb
  begin
    is_load  = 1'b0;
    is_store = 1'b0;
    rstrb    = '0;
    wstrb    = '0;
    case (req_i.op)
      OP_LB, OP_LBU:
      begin
        is_load = 1'b1;
        rstrb   = 4'h1;
      end
      OP_LH, OP_LHU:
      begin
        is_load = 1'b1;
        rstrb   = 4'h3;
      end
      OP_LW:
      begin
        is_load = 1'b1;
        rstrb   = 4'hF;
      end
      OP_SB:
      begin
        is_store = 1'b1;
        wstrb    = 4'h1;
      end
      OP_SH:
      begin
        is_store = 1'b1;
        wstrb    = 4'h3;
      end
      OP_SW:
      begin
        is_store = 1'b1;
        wstrb    = 4'hF;
      end
      default:
      begin
        is_load  = 1'b0;
        is_store = 1'b0;
      end
    endcase
  end

  assign is_load_o  = is_load;
  assign is_store_o = is_store;
  assign op_o       = req_i.op;

  // read channel, a hit never reaches the bus
  assign bus_rd_o.araddr = eff_addr_o;
  assign bus_rd_o.rstrb  = rstrb;
  assign bus_arvalid_o   = req_valid_i & is_load & ~hit_i;

  // write channel, one valid level for address and data
  assign bus_wr_o.awaddr = eff_addr_o;
  assign bus_wr_o.wdata  = req_i.wdata;
  assign bus_wr_o.wstrb  = wstrb;
  assign bus_wvalid_o    = req_valid_i & is_store;

  assign wready_o = bus_wready_i;

endmodule

//--- hw/l1d_cache.sv
module l1d_cache (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  eff_addr_i,
  input  logic                        is_load_i,
  input  logic                        is_store_i,
  input  logic                        req_valid_i,
  input  logic [lsu_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                        bus_rvalid_i,
  output logic                        hit_o,
  output logic [lsu_pkg::DATA_W-1:0]  hit_data_o
);

  import lsu_pkg::*;

  // line storage
  logic [DATA_W-1:0]    data_q  [L1D_LINES];
  logic [L1D_TAG_W-1:0] tag_q   [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;

  logic [L1D_TAG_W-1:0] addr_tag;
  logic [L1D_IDX_W-1:0] addr_idx;
  logic                 tag_match;
  logic                 in_window;
  logic                 fill;
  logic                 inval;

  // tag | index | 2 byte-offset bits
  assign addr_tag = eff_addr_i[ADDR_W-1:L1D_IDX_W+2];
  assign addr_idx = eff_addr_i[L1D_IDX_W+1:2];

  assign tag_match = valid_q[addr_idx] & (tag_q[addr_idx] == addr_tag);

  // only these address ranges may be cached
  always_comb
  begin
    in_window = 1'b0;
    if (eff_addr_i >= CACHE_WIN0_LO && eff_addr_i < CACHE_WIN0_HI)
    begin
      in_window = 1'b1;
    end
    if (eff_addr_i >= CACHE_WIN1_LO && eff_addr_i < CACHE_WIN1_HI)
    begin
      in_window = 1'b1;
    end
    if (eff_addr_i >= CACHE_WIN2_LO && eff_addr_i < CACHE_WIN2_HI)
    begin
      in_window = 1'b1;
    end
  end

  assign hit_o      = req_valid_i & is_load_i & tag_match;
  assign hit_data_o = data_q[addr_idx];

  // fill on the read response of a cacheable miss
  assign fill  = req_valid_i & is_load_i & bus_rvalid_i & in_window;

  // write-invalidate, no allocate on store
  assign inval = req_valid_i & is_store_i & tag_match;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_q <= '0;
    end
    else if (fill)
    begin
      valid_q[addr_idx] <= 1'b1;
    end
    else if (inval)
    begin
      valid_q[addr_idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      data_q[addr_idx] <= bus_rdata_i;
      tag_q[addr_idx]  <= addr_tag;
    end
  end

endmodule

//--- hw/lsu_load_align.sv
module lsu_load_align (
  input  logic                        hit_i,
  input  logic [lsu_pkg::DATA_W-1:0]  hit_data_i,
  input  logic [lsu_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                        bus_rvalid_i,
  input  logic [1:0]                  addr_lo_i,
  input  lsu_pkg::lsu_op_e            op_i,
  output logic [lsu_pkg::DATA_W-1:0]  rdata_o,
  output logic                        rvalid_o
);

  import lsu_pkg::*;

  lsu_word_u raw;
  lsu_word_u shifted;

  // bus response wins over the cache word
  assign raw.word = bus_rvalid_i ? bus_rdata_i : hit_data_i;

  // move the addressed byte down to lane 0
  always_comb
  begin
    int src;
    shifted.word = '0;
    for (int i = 0; i < STRB_W; i++)
    begin
      src = i + int'(addr_lo_i);
      if (src < STRB_W)
      begin
        shifted.bytes[i] = raw.bytes[src];
      end
    end
  end

  // size and sign handling
  always_comb
  begin
    case (op_i)
      OP_LB:
      begin
        rdata_o = {{(DATA_W-8){shifted.bytes[0][7]}}, shifted.bytes[0]};
      end
      OP_LBU:
      begin
        rdata_o = {{(DATA_W-8){1'b0}}, shifted.bytes[0]};
      end
      OP_LH:
      begin
        rdata_o = {{(DATA_W-16){shifted.word[15]}}, shifted.word[15:0]};
      end
      OP_LHU:
      begin
        rdata_o = {{(DATA_W-16){1'b0}}, shifted.word[15:0]};
      end
      OP_LW:
      begin
        rdata_o = shifted.word;
      end
      default:
      begin
        rdata_o = '0;
      end
    endcase
  end

  // either source ends the load
  assign rvalid_o = hit_i | bus_rvalid_i;

endmodule

//--- hw/lsu_top.sv
module lsu_top (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        addr_strobe_i,
  input  logic                        req_valid_i,
  input  lsu_pkg::lsu_req_t           req_i,
  output logic [lsu_pkg::DATA_W-1:0]  rdata_o,
  output logic                        rvalid_o,
  output logic                        wready_o,
  output lsu_pkg::bus_rd_req_t        bus_rd_o,
  output logic                        bus_arvalid_o,
  input  logic [lsu_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                        bus_rvalid_i,
  output lsu_pkg::bus_wr_req_t        bus_wr_o,
  output logic                        bus_wvalid_o,
  input  logic                        bus_wready_i
);

  import lsu_pkg::*;

  logic [ADDR_W-1:0] eff_addr;
  logic              is_load;
  logic              is_store;
  lsu_op_e           op;
  logic              hit;
  logic [DATA_W-1:0] hit_data;

  lsu_addr_ctrl i_addr_ctrl (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .addr_strobe_i (addr_strobe_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .hit_i         (hit),
    .bus_wready_i  (bus_wready_i),
    .eff_addr_o    (eff_addr),
    .is_load_o     (is_load),
    .is_store_o    (is_store),
    .op_o          (op),
    .bus_rd_o      (bus_rd_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_wr_o      (bus_wr_o),
    .bus_wvalid_o  (bus_wvalid_o),
    .wready_o      (wready_o)
  );

  l1d_cache i_l1d_cache (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .eff_addr_i   (eff_addr),
    .is_load_i    (is_load),
    .is_store_i   (is_store),
    .req_valid_i  (req_valid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .hit_o        (hit),
    .hit_data_o   (hit_data)
  );

  lsu_load_align i_load_align (
    .hit_i        (hit),
    .hit_data_i   (hit_data),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .addr_lo_i    (eff_addr[1:0]),
    .op_i         (op),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o)
  );

endmodule

//--- dv/lsu_props.sv
module lsu_props (
  input logic clk,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic rvalid_i,
  input logic bus_rvalid_i,
  input logic bus_arvalid_i,
  input logic bus_wvalid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // read and write never share the bus
  a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(bus_arvalid_i && bus_wvalid_i))
    else
    begin
      $error("bus_arvalid_o and bus_wvalid_o high in the same cycle");
      fail_count++;
    end

  a_rvalid_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    rvalid_i |-> req_valid_i)
    else
    begin
      $error("rvalid_o high without req_valid_i");
      fail_count++;
    end

  // a miss keeps its read up until the data returns
  a_miss_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_arvalid_i && !bus_rvalid_i |=> bus_arvalid_i)
    else
    begin
      $error("bus_arvalid_o dropped before bus_rvalid_i");
      fail_count++;
    end

endmodule

bind lsu_top lsu_props i_props (
  .clk           (clk),
  .rst_n_i       (rst_n_i),
  .req_valid_i   (req_valid_i),
  .rvalid_i      (rvalid_o),
  .bus_rvalid_i  (bus_rvalid_i),
  .bus_arvalid_i (bus_arvalid_o),
  .bus_wvalid_i  (bus_wvalid_o)
);

//--- dv/tb_lsu_top.sv
module tb_lsu_top;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int MEM_WORDS      = 256;

  typedef struct packed {
    lsu_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_bus_rd;
  } row_t;

  logic              clk;
  logic              rst_n_i;
  logic              addr_strobe_i;
  logic              req_valid_i;
  lsu_req_t          req_i;
  logic [DATA_W-1:0] rdata_o;
  logic              rvalid_o;
  logic              wready_o;
  bus_rd_req_t       bus_rd_o;
  logic              bus_arvalid_o;
  logic [DATA_W-1:0] bus_rdata_i;
  logic              bus_rvalid_i;
  bus_wr_req_t       bus_wr_o;
  logic              bus_wvalid_o;
  logic              bus_wready_i;

  // bus-side memory, 1 KiB per window plus one for uncached space
  logic [DATA_W-1:0]    bus_mem [4][MEM_WORDS];
  // mirror of memory and cache used for expected values
  logic [DATA_W-1:0]    ref_mem [4][MEM_WORDS];
  logic [L1D_LINES-1:0] ref_valid;
  logic [L1D_TAG_W-1:0] ref_tag [L1D_LINES];

  row_t        rows [$];
  integer      seed = 77326;
  int          rd_count;
  int          checks;
  int          errors;
  bus_wr_req_t wr_seen;
  bus_rd_req_t rd_seen;

  lsu_top i_dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // model memory number, 3 is everything outside the windows
  function automatic int region(input logic [ADDR_W-1:0] a);
    if (a >= CACHE_WIN0_LO && a < CACHE_WIN0_HI)
      return 0;
    if (a >= CACHE_WIN1_LO && a < CACHE_WIN1_HI)
      return 1;
    if (a >= CACHE_WIN2_LO && a < CACHE_WIN2_HI)
      return 2;
    return 3;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a[15:0], a[31:16]} ^ (a * 32'h0101_0101) ^ 32'h9C5A_E3B7;
  endfunction

  function automatic logic [STRB_W-1:0] store_strobe(input lsu_op_e op);
    case (op)
      OP_SB:   return 4'h1;
      OP_SH:   return 4'h3;
      OP_SW:   return 4'hF;
      default: return 4'h0;
    endcase
  endfunction

  function automatic logic [STRB_W-1:0] load_strobe(input lsu_op_e op);
    case (op)
      OP_LB, OP_LBU: return 4'h1;
      OP_LH, OP_LHU: return 4'h3;
      OP_LW:         return 4'hF;
      default:       return 4'h0;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] apply_strobe(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < STRB_W; b++)
      if (strb[b])
        w[8*b +: 8] = new_w[8*b +: 8];
    return w;
  endfunction

  // shift right by the byte offset, then size and sign
  function automatic logic [DATA_W-1:0] extend(input lsu_op_e op, input logic [DATA_W-1:0] w,
                                               input logic [1:0] off);
    logic [DATA_W-1:0] s;
    s = w >> (8 * off);
    case (op)
      OP_LB:   return {{24{s[7]}}, s[7:0]};
      OP_LBU:  return {24'h0, s[7:0]};
      OP_LH:   return {{16{s[15]}}, s[15:0]};
      OP_LHU:  return {16'h0, s[15:0]};
      OP_LW:   return s;
      default: return '0;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic init_memories();
    logic [ADDR_W-1:0] base [4];
    base = '{CACHE_WIN0_LO, CACHE_WIN1_LO, CACHE_WIN2_LO, 32'h1000_0000};
    for (int r = 0; r < 4; r++)
      for (int w = 0; w < MEM_WORDS; w++)
      begin
        bus_mem[r][w] = fill_word(base[r] + 4 * w);
        ref_mem[r][w] = fill_word(base[r] + 4 * w);
      end
    ref_valid = '0;
  endtask

  task automatic add_row(input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata);
    row_t row;
    row = {op, addr, wdata, 32'h0, 1'b0};
    rows.push_back(row);
  endtask

  task automatic build_table();
    lsu_op_e ops [4];
    ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU};
    // miss then hit
    add_row(OP_LW, 32'h8000_0010, 0);
    add_row(OP_LW, 32'h8000_0010, 0);
    // every byte has its sign bit set
    add_row(OP_SW, 32'h3000_0020, 32'hF182_C3E2);
    foreach (ops[k])
      for (int off = 0; off < 4; off++)
        add_row(ops[k], 32'h3000_0020 + off, 0);
    add_row(OP_SB, 32'hA000_0100, 32'h1234_56AB);
    add_row(OP_SH, 32'hA000_0104, 32'hAAAA_BEEF);
    add_row(OP_SW, 32'hA000_0108, 32'hDEAD_BEEF);
    add_row(OP_LW, 32'hA000_0100, 0);
    add_row(OP_LW, 32'hA000_0104, 0);
    add_row(OP_LW, 32'hA000_0108, 0);
    // store hit drops the line
    add_row(OP_LW, 32'h8000_0040, 0);
    add_row(OP_LW, 32'h8000_0040, 0);
    add_row(OP_SW, 32'h8000_0040, 32'h0BAD_F00D);
    add_row(OP_LW, 32'h8000_0040, 0);
    add_row(OP_LW, 32'h8000_0040, 0);
    // uncached space
    add_row(OP_LW, 32'h1000_0040, 0);
    add_row(OP_LW, 32'h1000_0040, 0);
    add_row(OP_LBU, 32'h1000_0043, 0);
    // same index, different tags
    add_row(OP_LW, 32'h3000_0080, 0);
    add_row(OP_LW, 32'h3000_0180, 0);
    add_row(OP_LW, 32'h3000_0080, 0);
    add_row(OP_LW, 32'h3000_0180, 0);
  endtask

  // walk the table through the mirror to fill in expected values
  task automatic predict();
    row_t                 row;
    logic [L1D_IDX_W-1:0] idx;
    logic [L1D_TAG_W-1:0] tag;
    logic [7:0]           w;
    logic                 hit;
    int                   r;
    foreach (rows[i])
    begin
      row = rows[i];
      idx = row.addr[L1D_IDX_W+1:2];
      tag = row.addr[ADDR_W-1:L1D_IDX_W+2];
      w   = row.addr[9:2];
      r   = region(row.addr);
      hit = ref_valid[idx] && ref_tag[idx] == tag;
      row.exp_rdata  = '0;
      row.exp_bus_rd = 1'b0;
      if (row.op inside {OP_SB, OP_SH, OP_SW})
      begin
        ref_mem[r][w] = apply_strobe(ref_mem[r][w], row.wdata, store_strobe(row.op));
        if (hit)
          ref_valid[idx] = 1'b0;
      end
      else
      begin
        row.exp_rdata  = extend(row.op, ref_mem[r][w], row.addr[1:0]);
        row.exp_bus_rd = !hit;
        // only window addresses are filled
        if (!hit && r != 3)
        begin
          ref_valid[idx] = 1'b1;
          ref_tag[idx]   = tag;
        end
      end
      rows[i] = row;
    end
  endtask

  task automatic apply_row(input int n);
    row_t              row;
    lsu_op_e           op;
    logic [DATA_W-1:0] got;
    logic              is_st;
    logic              done;
    int                cycles;
    int                base_rd;
    int                err0;
    row     = rows[n];
    op      = row.op;
    is_st   = op inside {OP_SB, OP_SH, OP_SW};
    err0    = errors;
    base_rd = rd_count;
    done    = 1'b0;
    cycles  = 0;
    got     = '0;
    @(posedge clk);
    #2;
    req_i         = {row.op, row.addr, row.wdata};
    addr_strobe_i = 1'b1;
    req_valid_i   = 1'b1;
    while (!done && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      if (is_st ? wready_o : rvalid_o)
      begin
        done = 1'b1;
        got  = rdata_o;
      end
      else
        cycles++;
      @(posedge clk);
      #2;
      addr_strobe_i = 1'b0;
      // later cycles must run on the latched address
      req_i.addr    = ~row.addr;
    end
    req_valid_i = 1'b0;
    req_i       = '0;
    if (!done)
    begin
      errors++;
      $display("row %0d timed out, no response after %0d cycles", n, TIMEOUT_CYCLES);
    end
    else if (is_st)
    begin
      check("bus_wr_o.awaddr", wr_seen.awaddr, row.addr);
      check("bus_wr_o.wdata", wr_seen.wdata, row.wdata);
      check("bus_wr_o.wstrb", wr_seen.wstrb, store_strobe(op));
      check("bus read count", rd_count - base_rd, 0);
    end
    else
    begin
      check("rdata_o", got, row.exp_rdata);
      check("bus read count", rd_count - base_rd, row.exp_bus_rd);
      if (row.exp_bus_rd)
      begin
        check("bus_rd_o.araddr", rd_seen.araddr, row.addr);
        check("bus_rd_o.rstrb", rd_seen.rstrb, load_strobe(op));
      end
      // a hit answers in the request cycle
      if (!row.exp_bus_rd)
        check("rvalid_o latency", cycles, 0);
    end
    $display("row %0d %s addr %h %s", n, op.name(), row.addr,
             (errors == err0) ? "ok" : "mismatch");
  endtask

  // bus memory, answers one access at a time after 1 to 4 cycles
  always
  begin : bus_responder
    logic [ADDR_W-1:0] a;
    logic              is_rd;
    int                r;
    @(posedge clk);
    if (rst_n_i && (bus_arvalid_o || bus_wvalid_o))
    begin
      is_rd = bus_arvalid_o;
      a     = is_rd ? bus_rd_o.araddr : bus_wr_o.awaddr;
      r     = region(a);
      if (is_rd)
      begin
        rd_count++;
        rd_seen = bus_rd_o;
      end
      else
      begin
        wr_seen = bus_wr_o;
        bus_mem[r][a[9:2]] = apply_strobe(bus_mem[r][a[9:2]], bus_wr_o.wdata, bus_wr_o.wstrb);
      end
      repeat ($unsigned($random(seed)) % 4) @(posedge clk);
      #2;
      bus_rdata_i  = bus_mem[r][a[9:2]];
      bus_rvalid_i = is_rd;
      bus_wready_i = !is_rd;
      @(posedge clk);
      #2;
      bus_rvalid_i = 1'b0;
      bus_wready_i = 1'b0;
    end
  end

  initial
  begin
    rst_n_i       = 1'b0;
    addr_strobe_i = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    bus_rdata_i   = '0;
    bus_rvalid_i  = 1'b0;
    bus_wready_i  = 1'b0;
    wr_seen       = '0;
    rd_seen       = '0;
    rd_count      = 0;
    checks        = 0;
    errors        = 0;
    init_memories();
    build_table();
    predict();
    repeat (10) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    foreach (rows[i])
      apply_row(i);
    errors = errors + i_dut.i_props.fail_count;
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- tb.f
hw/lsu_pkg.sv
hw/lsu_addr_ctrl.sv
hw/l1d_cache.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
dv/lsu_props.sv
dv/tb_lsu_top.sv
